//--- fcc_top.f
hw/fcc_pkg.sv
hw/fcc_fetch.sv
hw/fcc_dot_product.sv
hw/fcc_accum_act.sv
hw/fcc_writer.sv
hw/fcc_top.sv
bench/fcc_assert.sv
bench/fcc_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the FC accelerator testbench with Verilator
set -u

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module fcc_tb \
  -f fcc_top.f --Mdir "$BUILD_DIR" -o fcc_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/fcc_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q -F "** FAIL **" "$LOG"; then
  exit 1
fi
exit 0

//--- bench/fcc_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fcc_tb import fcc_pkg::*; ();

  //==========================================================================
  // Run setup
  //==========================================================================
  localparam int SEED = 47;
  localparam int CLK_HALF = 50;
  localparam int RESET_CYCLES = 3;
  localparam int NUM_RUNS = 3;
  localparam int MAX_ROWS = 8;
  localparam int ROW_BYTES = DP_DEPTH * CHUNKS_PER_ROW;
  localparam int MEM_BYTES = 1 << ADDR_WIDTH;
  // 3 runs x 8 rows x 4 chunks x 12 cycles is about 1.2k cycles
  // Limit keeps a wide margin for write waits and idle gaps
  localparam int CYCLE_LIMIT = 20000;

  // Operand styles, one per run
  localparam int MODE_SMALL = 0;
  localparam int MODE_NEG = 1;
  localparam int MODE_BIG = 2;

  // DUT inputs, all defined from time 0
  logic                     clk = 1'b0;
  logic                     rst_n = 1'b0;
  logic                     go = 1'b0;
  logic [ROW_CNT_WIDTH-1:0] num_rows = '0;
  addr_t                    addr_x = '0;
  addr_t                    addr_y = '0;
  addr_t                    addr_b = '0;
  addr_t                    addr_z = '0;
  logic                     rd_data_valid = 1'b0;
  chunk_t                   rd_data_data = '0;
  logic                     rd_wgt_valid = 1'b0;
  chunk_t                   rd_wgt_data = '0;
  logic                     rd_bias_valid = 1'b0;
  acc_t                     rd_bias_data = '0;
  logic                     wr_ack = 1'b0;

  // DUT outputs
  logic       rd_data_req;
  addr_t      rd_data_addr;
  logic       rd_wgt_req;
  addr_t      rd_wgt_addr;
  logic       rd_bias_req;
  addr_t      rd_bias_addr;
  logic       wr_req;
  addr_t      wr_addr;
  logic [7:0] wr_data;
  logic       done;
  logic       busy;

  // Byte memory behind all four channels
  logic [7:0] mem [MEM_BYTES];

  // Model results still to be written, in row order
  int exp_q[$];

  // Responder wait counters and per-run request counts
  int data_wait = 0;
  int wgt_wait = 0;
  int bias_wait = 0;
  int wr_wait = 0;
  int data_reqs = 0;
  int wgt_reqs = 0;
  int bias_reqs = 0;
  int writes = 0;

  int   check_count = 0;
  int   error_count = 0;
  int   cycle_count = 0;
  logic run_active = 1'b0;

  fcc_top dut_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .go            (go),
    .num_rows      (num_rows),
    .addr_x        (addr_x),
    .addr_y        (addr_y),
    .addr_b        (addr_b),
    .addr_z        (addr_z),
    .rd_data_req   (rd_data_req),
    .rd_data_addr  (rd_data_addr),
    .rd_data_valid (rd_data_valid),
    .rd_data_data  (rd_data_data),
    .rd_wgt_req    (rd_wgt_req),
    .rd_wgt_addr   (rd_wgt_addr),
    .rd_wgt_valid  (rd_wgt_valid),
    .rd_wgt_data   (rd_wgt_data),
    .rd_bias_req   (rd_bias_req),
    .rd_bias_addr  (rd_bias_addr),
    .rd_bias_valid (rd_bias_valid),
    .rd_bias_data  (rd_bias_data),
    .wr_req        (wr_req),
    .wr_addr       (wr_addr),
    .wr_data       (wr_data),
    .wr_ack        (wr_ack),
    .done          (done),
    .busy          (busy)
  );

  // 100 ns clock
  always #CLK_HALF clk = ~clk;

  //==========================================================================
  // Helpers
  //==========================================================================
  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    check_count++;
    if (actual !== expected)
    begin
      error_count++;
      $display("Mismatch %s: expected %0d, actual %0d at %0t", name, expected, actual,
               $time);
    end
  endtask

  // Lane i of the chunk from byte base+i
  function automatic chunk_t read_chunk(input int base);
    chunk_t c;
    for (int i = 0; i < DP_DEPTH; i++)
      c[8*i +: 8] = mem[base + i];
    return c;
  endfunction

  // Little-endian 32-bit word
  function automatic int read_word(input int base);
    return {mem[base + 3], mem[base + 2], mem[base + 1], mem[base]};
  endfunction

  // Scaled ReLU with saturation
  function automatic int activate(input int total);
    if (total < 0)
      return 0;
    if ((total >>> LOG2_SCALE) > OUT_MAX)
      return OUT_MAX;
    return total >>> LOG2_SCALE;
  endfunction

  task automatic fill_operands(input int mode, input int rows);
    int bias;
    // Data vector, one row's worth
    for (int j = 0; j < ROW_BYTES; j++)
    begin
      if (mode == MODE_BIG)
        mem[int'(addr_x) + j] = 8'($urandom_range(128, 255));
      else
        mem[int'(addr_x) + j] = 8'($urandom_range(0, 255));
    end
    // Weights: small around zero, all negative, or large positive
    for (int j = 0; j < rows * ROW_BYTES; j++)
    begin
      case (mode)
        MODE_SMALL: mem[int'(addr_y) + j] = 8'(int'($urandom_range(0, 6)) - 3);
        MODE_NEG:   mem[int'(addr_y) + j] = 8'($urandom_range(128, 255));
        default:    mem[int'(addr_y) + j] = 8'($urandom_range(64, 127));
      endcase
    end
    for (int r = 0; r < rows; r++)
    begin
      case (mode)
        MODE_SMALL: bias = int'($urandom_range(0, 8191)) - 4096;
        MODE_NEG:   bias = -int'($urandom_range(1, 1 << 20));
        default:    bias = int'($urandom_range(0, 1 << 20));
      endcase
      for (int b = 0; b < 4; b++)
        mem[int'(addr_b) + 4 * r + b] = 8'(bias >> (8 * b));
    end
  endtask

  // Reference: unsigned data times signed weights plus bias, then activation
  task automatic compute_expected(input int rows);
    int  total;
    byte w;
    exp_q.delete();
    for (int r = 0; r < rows; r++)
    begin
      total = read_word(int'(addr_b) + 4 * r);
      for (int j = 0; j < ROW_BYTES; j++)
      begin
        w = mem[int'(addr_y) + r * ROW_BYTES + j];
        total += int'(mem[int'(addr_x) + j]) * int'(w);
      end
      exp_q.push_back(activate(total));
    end
  endtask

  task automatic record_write();
    if (exp_q.size() == 0)
    begin
      error_count++;
      $display("Unexpected write of %0d to address %0d with no row pending", wr_data,
               wr_addr);
    end
    else
    begin
      compare_value("write address", int'(addr_z) + writes, wr_addr);
      compare_value("result byte", exp_q.pop_front(), wr_data);
    end
    writes++;
  endtask

  //==========================================================================
  // Memory responders, random 1 to 4 cycle read latency
  //==========================================================================
  always @(negedge clk)
  begin
    rd_data_valid = 1'b0;
    if (data_wait > 0)
    begin
      data_wait--;
      if (data_wait == 0)
      begin
        rd_data_valid = 1'b1;
        rd_data_data = read_chunk(int'(rd_data_addr));
      end
    end
    else if (rst_n && rd_data_req)
    begin
      // Data restarts at addr_x on each row
      compare_value("data address", int'(addr_x) + (data_reqs % CHUNKS_PER_ROW) * DP_DEPTH,
                    rd_data_addr);
      data_reqs++;
      data_wait = $urandom_range(1, 4);
    end
  end

  always @(negedge clk)
  begin
    rd_wgt_valid = 1'b0;
    if (wgt_wait > 0)
    begin
      wgt_wait--;
      if (wgt_wait == 0)
      begin
        rd_wgt_valid = 1'b1;
        rd_wgt_data = read_chunk(int'(rd_wgt_addr));
      end
    end
    else if (rst_n && rd_wgt_req)
    begin
      // Weights walk the matrix chunk by chunk
      compare_value("weight address", int'(addr_y) + wgt_reqs * DP_DEPTH, rd_wgt_addr);
      wgt_reqs++;
      wgt_wait = $urandom_range(1, 4);
    end
  end

  always @(negedge clk)
  begin
    rd_bias_valid = 1'b0;
    if (bias_wait > 0)
    begin
      bias_wait--;
      if (bias_wait == 0)
      begin
        rd_bias_valid = 1'b1;
        rd_bias_data = acc_t'(read_word(int'(rd_bias_addr)));
      end
    end
    else if (rst_n && rd_bias_req)
    begin
      compare_value("bias address", int'(addr_b) + bias_reqs * 4, rd_bias_addr);
      bias_reqs++;
      bias_wait = $urandom_range(1, 4);
    end
  end

  // Write side, ack after 1 to 6 cycles
  always @(negedge clk)
  begin
    wr_ack = 1'b0;
    if (wr_wait > 0)
    begin
      wr_wait--;
      if (wr_wait == 0)
      begin
        wr_ack = 1'b1;
        record_write();
      end
    end
    else if (rst_n && wr_req)
      wr_wait = $urandom_range(1, 6);
  end

  // busy must hold from go until done
  always @(negedge clk)
  begin
    if (run_active && !done)
      compare_value("busy during run", 1, busy);
  end

  //==========================================================================
  // Runs
  //==========================================================================
  task automatic run_layer(input int mode);
    int rows;
    rows = $urandom_range(1, MAX_ROWS);
    // Disjoint regions, random offsets
    addr_x = addr_t'(32'h01000 + $urandom_range(0, 255));
    addr_y = addr_t'(32'h10000 + $urandom_range(0, 1023));
    addr_b = addr_t'(32'h20000 + $urandom_range(0, 255));
    addr_z = addr_t'(32'h30000 + $urandom_range(0, 255));
    num_rows = ROW_CNT_WIDTH'(rows);
    fill_operands(mode, rows);
    compute_expected(rows);
    data_reqs = 0;
    wgt_reqs = 0;
    bias_reqs = 0;
    writes = 0;
    go = 1'b1;
    @(negedge clk);
    go = 1'b0;
    // Fetch has left IDLE on that edge
    compare_value("busy after go", 1, busy);
    compare_value("done cleared by go", 0, done);
    run_active = 1'b1;
    while (!done)
      @(negedge clk);
    run_active = 1'b0;
    compare_value("writes per run", rows, writes);
    compare_value("results left over", 0, exp_q.size());
    compare_value("busy at done", 0, busy);
    // done stays up while idle
    repeat ($urandom_range(2, 6))
    begin
      @(negedge clk);
      compare_value("done held", 1, done);
      compare_value("busy while idle", 0, busy);
    end
  endtask

  initial
  begin
    void'($urandom(SEED));
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    compare_value("busy after reset", 0, busy);
    compare_value("done after reset", 0, done);
    for (int run = 0; run < NUM_RUNS; run++)
      run_layer(run);
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

  // Hang guard
  always @(posedge clk)
  begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT)
    begin
      $display("Timeout: the runs did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Checks: %0d, errors: %0d", check_count, error_count);
      $display("** FAIL **");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- bench/fcc_assert.sv
`timescale 1ns/1ps
`default_nettype none

module fcc_assert import fcc_pkg::*; (
  input wire        clk,
  input wire        rst_n,
  input wire        busy,
  input wire        rd_data_req,
  input wire addr_t rd_data_addr,
  input wire        rd_data_valid,
  input wire        rd_wgt_req,
  input wire addr_t rd_wgt_addr,
  input wire        rd_wgt_valid,
  input wire        rd_bias_req,
  input wire addr_t rd_bias_addr,
  input wire        rd_bias_valid,
  input wire        wr_req,
  input wire addr_t wr_addr,
  input wire [7:0]  wr_data,
  input wire        wr_ack
);

  //==========================================================================
  // Read requests hold with a fixed address until valid
  //==========================================================================
  data_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
    rd_data_req && !rd_data_valid |=> rd_data_req && $stable(rd_data_addr))
    else $error("data read request dropped or address moved before valid");

  wgt_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
    rd_wgt_req && !rd_wgt_valid |=> rd_wgt_req && $stable(rd_wgt_addr))
    else $error("weight read request dropped or address moved before valid");

  bias_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
    rd_bias_req && !rd_bias_valid |=> rd_bias_req && $stable(rd_bias_addr))
    else $error("bias read request dropped or address moved before valid");

  //==========================================================================
  // Write side
  //==========================================================================
  wr_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
    wr_req && !wr_ack |=> wr_req && $stable(wr_addr))
    else $error("write request dropped or address moved before ack");

  // Payload fixed for the life of the request
  wr_data_stable: assert property (@(posedge clk) disable iff (!rst_n)
    wr_req |=> !wr_req || $stable(wr_data))
    else $error("write data changed while the request was pending");

  // Nothing on the bus once idle
  idle_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    !busy |-> !(rd_data_req || rd_wgt_req || rd_bias_req || wr_req))
    else $error("request raised while the accelerator is not busy");

endmodule

bind fcc_top fcc_assert assert_i (
  .clk           (clk),
  .rst_n         (rst_n),
  .busy          (busy),
  .rd_data_req   (rd_data_req),
  .rd_data_addr  (rd_data_addr),
  .rd_data_valid (rd_data_valid),
  .rd_wgt_req    (rd_wgt_req),
  .rd_wgt_addr   (rd_wgt_addr),
  .rd_wgt_valid  (rd_wgt_valid),
  .rd_bias_req   (rd_bias_req),
  .rd_bias_addr  (rd_bias_addr),
  .rd_bias_valid (rd_bias_valid),
  .wr_req        (wr_req),
  .wr_addr       (wr_addr),
  .wr_data       (wr_data),
  .wr_ack        (wr_ack)
);

`default_nettype wire

//--- hw/fcc_top.sv
`timescale 1ns/1ps
`default_nettype none

module fcc_top import fcc_pkg::*; (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire                     go,
  input  wire [ROW_CNT_WIDTH-1:0] num_rows,
  input  addr_t                   addr_x,
  input  addr_t                   addr_y,
  input  addr_t                   addr_b,
  input  addr_t                   addr_z,
  // Data vector read
  output logic                    rd_data_req,
  output addr_t                   rd_data_addr,
  input  wire                     rd_data_valid,
  input  chunk_t                  rd_data_data,
  // Weight matrix read
  output logic                    rd_wgt_req,
  output addr_t                   rd_wgt_addr,
  input  wire                     rd_wgt_valid,
  input  chunk_t                  rd_wgt_data,
  // Bias read
  output logic                    rd_bias_req,
  output addr_t                   rd_bias_addr,
  input  wire                     rd_bias_valid,
  input  acc_t                    rd_bias_data,
  // Result write
  output logic                    wr_req,
  output addr_t                   wr_addr,
  output logic [7:0]              wr_data,
  input  wire                     wr_ack,
  output logic                    done,
  output logic                    busy
);

  //==========================================================================
  // Stage to stage wiring
  //==========================================================================
  // fetch -> dot product
  logic   chunk_valid;
  chunk_t chunk_data;
  chunk_t chunk_wgt;
  acc_t   chunk_bias;
  logic   chunk_last;

  // dot product -> accumulator
  logic part_valid;
  acc_t part_sum;
  acc_t part_bias;
  logic part_last;

  // accumulator -> writer
  logic       res_valid;
  logic [7:0] res_byte;

  // writer -> fetch
  logic row_written;

  fcc_fetch fetch_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .go            (go),
    .num_rows      (num_rows),
    .addr_x        (addr_x),
    .addr_y        (addr_y),
    .addr_b        (addr_b),
    .row_written   (row_written),
    .rd_data_req   (rd_data_req),
    .rd_data_addr  (rd_data_addr),
    .rd_data_valid (rd_data_valid),
    .rd_data_data  (rd_data_data),
    .rd_wgt_req    (rd_wgt_req),
    .rd_wgt_addr   (rd_wgt_addr),
    .rd_wgt_valid  (rd_wgt_valid),
    .rd_wgt_data   (rd_wgt_data),
    .rd_bias_req   (rd_bias_req),
    .rd_bias_addr  (rd_bias_addr),
    .rd_bias_valid (rd_bias_valid),
    .rd_bias_data  (rd_bias_data),
    .chunk_valid   (chunk_valid),
    .chunk_data    (chunk_data),
    .chunk_wgt     (chunk_wgt),
    .chunk_bias    (chunk_bias),
    .chunk_last    (chunk_last),
    .done          (done),
    .busy          (busy)
  );

  fcc_dot_product dot_product_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .chunk_valid (chunk_valid),
    .chunk_data  (chunk_data),
    .chunk_wgt   (chunk_wgt),
    .chunk_bias  (chunk_bias),
    .chunk_last  (chunk_last),
    .part_valid  (part_valid),
    .part_sum    (part_sum),
    .part_bias   (part_bias),
    .part_last   (part_last)
  );

  fcc_accum_act accum_act_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .part_valid (part_valid),
    .part_sum   (part_sum),
    .part_bias  (part_bias),
    .part_last  (part_last),
    .res_valid  (res_valid),
    .res_byte   (res_byte)
  );

  // Writer sees busy to restart its row offset between runs
  fcc_writer writer_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .addr_z      (addr_z),
    .busy        (busy),
    .res_valid   (res_valid),
    .res_byte    (res_byte),
    .wr_ack      (wr_ack),
    .wr_req      (wr_req),
    .wr_addr     (wr_addr),
    .wr_data     (wr_data),
    .row_written (row_written)
  );

endmodule

`default_nettype wire

//--- hw/fcc_writer.sv
`timescale 1ns/1ps
`default_nettype none

module fcc_writer import fcc_pkg::*; (
  input  wire        clk,
  input  wire        rst_n,
  input  addr_t      addr_z,
  input  wire        busy,
  input  wire        res_valid,
  input  wire [7:0]  res_byte,
  input  wire        wr_ack,
  output logic       wr_req,
  output addr_t      wr_addr,
  output logic [7:0] wr_data,
  output logic       row_written
);

  // Row offset into the output vector
  logic [ROW_CNT_WIDTH-1:0] row_off_q;
  logic                     wr_done;

  assign wr_done = wr_req && wr_ack;

  //==========================================================================
  // Write request and row tracking
  //==========================================================================
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_req      <= 1'b0;
      row_written <= 1'b0;
      row_off_q   <= '0;
    end
    else
    begin
      // Pulse back to fetch, one cycle after the ack
      row_written <= wr_done;

      // Held until acked
      if (wr_done)
        wr_req <= 1'b0;
      else if (res_valid)
        wr_req <= 1'b1;

      // Fetch goes idle only after the last row is written, so the
      // next run's first result lands at addr_z again
      if (!busy)
        row_off_q <= '0;
      else if (wr_done)
        row_off_q <= row_off_q + 1'b1;
    end
  end

  // Result byte, stable for the life of the request
  always_ff @(posedge clk)
  begin
    if (res_valid)
      wr_data <= res_byte;
  end

  assign wr_addr = addr_z + addr_t'(row_off_q);

endmodule

`default_nettype wire

//--- hw/fcc_accum_act.sv
`timescale 1ns/1ps
`default_nettype none

module fcc_accum_act import fcc_pkg::*; (
  input  wire        clk,
  input  wire        rst_n,
  input  wire        part_valid,
  input  acc_t       part_sum,
  input  acc_t       part_bias,
  input  wire        part_last,
  output logic       res_valid,
  output logic [7:0] res_byte
);

  // Running sum of the partial products of the current row
  acc_t       acc_q;
  acc_t       row_total;
  acc_t       scaled;
  logic [7:0] act_byte;

  //==========================================================================
  // Row total and scaled ReLU
  //==========================================================================
  // Bias folded in together with the last part
  assign row_total = acc_q + part_sum + part_bias;
  assign scaled    = row_total >>> LOG2_SCALE;

  always_comb
  begin
    if (row_total < 0)
      act_byte = 8'd0;
    else if (scaled > acc_t'(OUT_MAX))
      act_byte = 8'(OUT_MAX);
    else
      act_byte = scaled[7:0];
  end

  //==========================================================================
  // Accumulator and result register
  //==========================================================================
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      acc_q     <= '0;
      res_valid <= 1'b0;
    end
    else
    begin
      res_valid <= part_valid && part_last;
      if (part_valid)
      begin
        // Clear on the last part, ready for the next row
        if (part_last)
          acc_q <= '0;
        else
          acc_q <= acc_q + part_sum;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (part_valid && part_last)
      res_byte <= act_byte;
  end

endmodule

`default_nettype wire

//--- hw/fcc_dot_product.sv
`timescale 1ns/1ps
`default_nettype none

module fcc_dot_product import fcc_pkg::*; (
  input  wire    clk,
  input  wire    rst_n,
  input  wire    chunk_valid,
  input  chunk_t chunk_data,
  input  chunk_t chunk_wgt,
  input  acc_t   chunk_bias,
  input  wire    chunk_last,
  output logic   part_valid,
  output acc_t   part_sum,
  output acc_t   part_bias,
  output logic   part_last
);

  acc_t dot_sum;

  //==========================================================================
  // 32-lane multiply and adder tree
  //==========================================================================
  always_comb
  begin
    logic signed [16:0] prod;
    dot_sum = '0;
    for (int i = 0; i < DP_DEPTH; i++)
    begin
      // Unsigned data byte, zero-extended so the product stays signed
      prod = $signed({1'b0, chunk_data[8*i +: 8]}) * $signed(chunk_wgt[8*i +: 8]);
      dot_sum = dot_sum + acc_t'(prod);
    end
  end

  // Valid pipeline, one stage
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      part_valid <= 1'b0;
    else
      part_valid <= chunk_valid;
  end

  // Sum and side fields, loaded only with a chunk
  always_ff @(posedge clk)
  begin
    if (chunk_valid)
    begin
      part_sum  <= dot_sum;
      part_bias <= chunk_bias;
      part_last <= chunk_last;
    end
  end

endmodule

`default_nettype wire

//--- hw/fcc_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module fcc_fetch import fcc_pkg::*; (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire                     go,
  input  wire [ROW_CNT_WIDTH-1:0] num_rows,
  input  addr_t                   addr_x,
  input  addr_t                   addr_y,
  input  addr_t                   addr_b,
  input  wire                     row_written,
  // Read channels
  output logic                    rd_data_req,
  output addr_t                   rd_data_addr,
  input  wire                     rd_data_valid,
  input  chunk_t                  rd_data_data,
  output logic                    rd_wgt_req,
  output addr_t                   rd_wgt_addr,
  input  wire                     rd_wgt_valid,
  input  chunk_t                  rd_wgt_data,
  output logic                    rd_bias_req,
  output addr_t                   rd_bias_addr,
  input  wire                     rd_bias_valid,
  input  acc_t                    rd_bias_data,
  // Operands towards the dot product
  output logic                    chunk_valid,
  output chunk_t                  chunk_data,
  output chunk_t                  chunk_wgt,
  output acc_t                    chunk_bias,
  output logic                    chunk_last,
  // Status
  output logic                    done,
  output logic                    busy
);

  fetch_state_e               state_q;
  logic [ROW_CNT_WIDTH-1:0]   row_q;
  logic [ROW_CNT_WIDTH-1:0]   num_rows_q;
  logic [CHUNK_CNT_WIDTH-1:0] chunk_q;

  // Captured flags, one per channel
  logic data_got_q;
  logic wgt_got_q;
  logic bias_got_q;

  // Operand holding registers
  chunk_t data_q;
  chunk_t wgt_q;
  acc_t   bias_q;

  logic bias_needed;
  logic operands_ready;
  logic last_row;

  //==========================================================================
  // Request side
  //==========================================================================
  // Bias only fetched once per row, on chunk 0
  assign bias_needed = (chunk_q == '0);
  assign operands_ready = data_got_q && wgt_got_q && (bias_got_q || !bias_needed);
  assign last_row = (row_q == num_rows_q - 1'b1);

  // Each req drops the cycle after its valid via the captured flag
  assign rd_data_req = (state_q == REQ) && !data_got_q;
  assign rd_wgt_req  = (state_q == REQ) && !wgt_got_q;
  assign rd_bias_req = (state_q == REQ) && bias_needed && !bias_got_q;

  // Data vector restarts at addr_x on every row
  assign rd_data_addr = addr_x + (addr_t'(chunk_q) << CHUNK_SHIFT);
  // Weights walk the matrix linearly, row then chunk
  assign rd_wgt_addr  = addr_y + (addr_t'({row_q, chunk_q}) << CHUNK_SHIFT);
  assign rd_bias_addr = addr_b + (addr_t'(row_q) << BIAS_SHIFT);

  //==========================================================================
  // Sequencer
  //==========================================================================
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q    <= IDLE;
      row_q      <= '0;
      chunk_q    <= '0;
      num_rows_q <= '0;
      busy       <= 1'b0;
      done       <= 1'b0;
    end
    else
    begin
      case (state_q)
        IDLE:
        begin
          // New run, done drops with the go
          if (go)
          begin
            state_q    <= REQ;
            row_q      <= '0;
            chunk_q    <= '0;
            num_rows_q <= num_rows;
            busy       <= 1'b1;
            done       <= 1'b0;
          end
        end
        REQ:
        begin
          if (operands_ready)
            state_q <= ISSUE;
        end
        ISSUE:
        begin
          // Counter wraps back to 0 after the last chunk
          chunk_q <= chunk_q + 1'b1;
          state_q <= chunk_last ? WAIT_WB : REQ;
        end
        WAIT_WB:
        begin
          // Hold here until the writer has the row in memory
          if (row_written)
          begin
            if (last_row)
            begin
              state_q <= IDLE;
              done    <= 1'b1;
              busy    <= 1'b0;
            end
            else
            begin
              row_q   <= row_q + 1'b1;
              state_q <= REQ;
            end
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  //==========================================================================
  // Response capture
  //==========================================================================
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      data_got_q <= 1'b0;
      wgt_got_q  <= 1'b0;
      bias_got_q <= 1'b0;
    end
    else if (state_q == ISSUE)
    begin
      // Chunk handed off, arm for the next one
      data_got_q <= 1'b0;
      wgt_got_q  <= 1'b0;
      bias_got_q <= 1'b0;
    end
    else
    begin
      if (rd_data_valid)
        data_got_q <= 1'b1;
      if (rd_wgt_valid)
        wgt_got_q <= 1'b1;
      if (rd_bias_valid)
        bias_got_q <= 1'b1;
    end
  end

  // Payload only, qualified by the flags above
  always_ff @(posedge clk)
  begin
    if (rd_data_valid)
      data_q <= rd_data_data;
    if (rd_wgt_valid)
      wgt_q <= rd_wgt_data;
    // Bias stays put for chunks 1..3 of the row
    if (rd_bias_valid)
      bias_q <= rd_bias_data;
  end

  // One-cycle hand-off while in ISSUE
  assign chunk_valid = (state_q == ISSUE);
  assign chunk_last  = (chunk_q == CHUNK_CNT_WIDTH'(CHUNKS_PER_ROW - 1));
  assign chunk_data  = data_q;
  assign chunk_wgt   = wgt_q;
  assign chunk_bias  = bias_q;

endmodule

`default_nettype wire

//--- hw/fcc_pkg.sv
`default_nettype none

//==========================================================================
// Shared sizes, types and encodings of the FC accelerator
//==========================================================================
package fcc_pkg;

  // Bytes per chunk, one chunk per read beat
  localparam int DP_DEPTH = 32;
  // Chunks needed to cover one 128-byte row
  localparam int CHUNKS_PER_ROW = 4;
  localparam int CHUNK_CNT_WIDTH = $clog2(CHUNKS_PER_ROW);
  // Packed chunk, byte lane i at bits 8i+7:8i
  localparam int CHUNK_WIDTH = DP_DEPTH * 8;
  // Byte offset of one chunk expressed as a shift
  localparam int CHUNK_SHIFT = $clog2(DP_DEPTH);

  // Memory side
  localparam int ADDR_WIDTH = 19;

  // Accumulator and bias share one width
  localparam int ACC_WIDTH = 32;
  // Bias entries are ACC_WIDTH/8 bytes apart
  localparam int BIAS_SHIFT = $clog2(ACC_WIDTH / 8);

  // Row counter, up to 128 rows with room to spare
  localparam int ROW_CNT_WIDTH = 8;

  // Activation: shift right then clamp
  localparam int LOG2_SCALE = 8;
  localparam int OUT_MAX = 255;

  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic signed [ACC_WIDTH-1:0] acc_t;
  typedef logic [CHUNK_WIDTH-1:0] chunk_t;

  // Fetch sequencer states
  typedef enum logic [1:0] {
    IDLE,
    REQ,
    ISSUE,
    WAIT_WB
  } fetch_state_e;

endpackage

`default_nettype wire
